//--- logic/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// architectural register file
`define EXEC_NREGS 32
`define EXEC_XLEN 32
`define EXEC_RADDR_W 5

// input queue depth, equal to the upstream credit count
`define EXEC_IN_DEPTH 4

// result beats downstream can hold
`define EXEC_OUT_CREDITS 2

`endif

//--- logic/uop_pkg.sv
`include "exec_params.svh"

package uop_pkg;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLT = 3'd5,
		SLL = 3'd6,
		LUI = 3'd7
	} alu_op_e;

	// one decoded integer instruction
	typedef struct packed {
		logic                     valid;
		alu_op_e                  op;
		logic [`EXEC_RADDR_W-1:0] rd;
		logic [`EXEC_RADDR_W-1:0] rs;
		logic [`EXEC_RADDR_W-1:0] rt;
		logic [15:0]              imm;
		logic                     use_imm;
	} uop_t;

	// slot0 is older in program order
	typedef struct packed {
		uop_t slot0;
		uop_t slot1;
	} bundle_t;

endpackage

//--- logic/wb_pkg.sv
`include "exec_params.svh"

package wb_pkg;

	typedef struct packed {
		logic                     valid;
		logic [`EXEC_RADDR_W-1:0] rd;
		logic [`EXEC_XLEN-1:0]    value;
	} wb_lane_t;

	// lane0 is older than lane1
	typedef struct packed {
		wb_lane_t lane0;
		wb_lane_t lane1;
	} wb_beat_t;

endpackage

//--- logic/bundle_queue.sv
`include "exec_params.svh"

module bundle_queue (
	input  logic             clk,
	input  logic             aresetn,
	input  logic             push,
	input  uop_pkg::bundle_t push_data,
	input  logic             pop,
	output uop_pkg::bundle_t head,
	output logic             head_valid,
	output logic             credit
);
	import uop_pkg::*;

	localparam int PTR_W = $clog2(`EXEC_IN_DEPTH);
	localparam int CNT_W = $clog2(`EXEC_IN_DEPTH + 1);

	bundle_t          mem [`EXEC_IN_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap at the last entry
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`EXEC_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`EXEC_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count  <= count + CNT_W'(push) - CNT_W'(pop);
			// one credit back per freed entry
			credit <= pop;
		end
	end

endmodule

//--- logic/issue_ctrl.sv
`include "exec_params.svh"

module issue_ctrl (
	input  logic                          clk,
	input  logic                          aresetn,
	input  uop_pkg::bundle_t              q_bundle,
	input  logic                          q_valid,
	output logic                          q_pop,
	output logic [3:0][`EXEC_RADDR_W-1:0] raddr,
	input  logic [3:0][`EXEC_XLEN-1:0]    rdata,
	output uop_pkg::uop_t                 alu_uop0,
	output uop_pkg::uop_t                 alu_uop1,
	output logic [`EXEC_XLEN-1:0]         alu_a0,
	output logic [`EXEC_XLEN-1:0]         alu_b0,
	output logic [`EXEC_XLEN-1:0]         alu_a1,
	output logic [`EXEC_XLEN-1:0]         alu_b1,
	input  logic [`EXEC_XLEN-1:0]         alu_res0,
	input  logic [`EXEC_XLEN-1:0]         alu_res1,
	input  logic                          out_credit,
	output wb_pkg::wb_beat_t              wb_q,
	output logic                          out_valid
);
	import uop_pkg::*;

	localparam int CNT_W = $clog2(`EXEC_OUT_CREDITS + 1);

	uop_t             s0;
	uop_t             s1;
	logic             half_q;
	logic [CNT_W-1:0] credit_cnt;
	logic             split;
	logic             issue;

	assign s0 = q_bundle.slot0;
	assign s1 = q_bundle.slot1;

	// slot1 reads what slot0 writes
	assign split = s0.valid && s1.valid && (s0.rd != '0) &&
		((s1.op != LUI && s1.rs == s0.rd) || (!s1.use_imm && s1.rt == s0.rd));

	assign issue = q_valid && (credit_cnt != '0);
	assign q_pop = issue && (half_q || !split);

	// after a split, the waiting slot1 goes out on lane0
	always_comb begin
		alu_uop0 = half_q ? s1 : s0;
		alu_uop1 = s1;
		if (half_q || split) begin
			alu_uop1.valid = 1'b0;
		end
	end

	assign raddr[0] = alu_uop0.rs;
	assign raddr[1] = alu_uop0.rt;
	assign raddr[2] = alu_uop1.rs;
	assign raddr[3] = alu_uop1.rt;

	assign alu_a0 = (alu_uop0.op == LUI) ? '0 : rdata[0];
	assign alu_b0 = alu_uop0.use_imm ? {{(`EXEC_XLEN - 16){1'b0}}, alu_uop0.imm} : rdata[1];
	assign alu_a1 = (alu_uop1.op == LUI) ? '0 : rdata[2];
	assign alu_b1 = alu_uop1.use_imm ? {{(`EXEC_XLEN - 16){1'b0}}, alu_uop1.imm} : rdata[3];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			half_q           <= 1'b0;
			credit_cnt       <= CNT_W'(`EXEC_OUT_CREDITS);
			out_valid        <= 1'b0;
			wb_q.lane0.valid <= 1'b0;
			wb_q.lane1.valid <= 1'b0;
		end else begin
			if (issue) begin
				half_q           <= !half_q && split;
				wb_q.lane0.rd    <= alu_uop0.rd;
				wb_q.lane0.value <= alu_res0;
				wb_q.lane1.rd    <= alu_uop1.rd;
				wb_q.lane1.value <= alu_res1;
			end
			// a beat takes its credit as it is loaded
			credit_cnt       <= credit_cnt - CNT_W'(issue) + CNT_W'(out_credit);
			out_valid        <= issue;
			wb_q.lane0.valid <= issue && alu_uop0.valid;
			wb_q.lane1.valid <= issue && alu_uop1.valid;
		end
	end

endmodule

//--- logic/regfile.sv
`include "exec_params.svh"

module regfile (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     we1,
	input  logic [`EXEC_RADDR_W-1:0] waddr1,
	input  logic [`EXEC_XLEN-1:0]    wdata1,
	input  logic                     we2,
	input  logic [`EXEC_RADDR_W-1:0] waddr2,
	input  logic [`EXEC_XLEN-1:0]    wdata2,
	input  logic [`EXEC_RADDR_W-1:0] raddr1,
	input  logic [`EXEC_RADDR_W-1:0] raddr2,
	input  logic [`EXEC_RADDR_W-1:0] raddr3,
	input  logic [`EXEC_RADDR_W-1:0] raddr4,
	output logic [`EXEC_XLEN-1:0]    rdata1,
	output logic [`EXEC_XLEN-1:0]    rdata2,
	output logic [`EXEC_XLEN-1:0]    rdata3,
	output logic [`EXEC_XLEN-1:0]    rdata4,
	output logic [`EXEC_XLEN-1:0]    link_reg
);

	logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

	// port 2 carries the younger result, so it wins the bypass
	function automatic logic [`EXEC_XLEN-1:0] read_port(
		input logic [`EXEC_RADDR_W-1:0] addr
	);
		if (!aresetn || addr == '0) begin
			return '0;
		end else if (we2 && addr == waddr2) begin
			return wdata2;
		end else if (we1 && addr == waddr1) begin
			return wdata1;
		end
		return regs[addr];
	endfunction

	// r1 holds the branch-and-link return address
	assign link_reg = regs[1];

	always_ff @(posedge clk) begin
		if (we2 && waddr2 != '0) begin
			regs[waddr2] <= wdata2;
		end
		// waw inside a beat keeps the port 2 value
		if (we1 && waddr1 != '0 && !(we2 && waddr2 == waddr1)) begin
			regs[waddr1] <= wdata1;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
		rdata3 = read_port(raddr3);
		rdata4 = read_port(raddr4);
	end

endmodule

//--- logic/int_alu.sv
`include "exec_params.svh"

module int_alu (
	input  uop_pkg::alu_op_e      op,
	input  logic [`EXEC_XLEN-1:0] a,
	input  logic [`EXEC_XLEN-1:0] b,
	output logic [`EXEC_XLEN-1:0] result
);
	import uop_pkg::*;

	always_comb begin
		case (op)
			ADD: begin
				result = a + b;
			end
			SUB: begin
				result = a - b;
			end
			AND: begin
				result = a & b;
			end
			OR: begin
				result = a | b;
			end
			XOR: begin
				result = a ^ b;
			end
			// signed compare
			SLT: begin
				result = {{(`EXEC_XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
			end
			SLL: begin
				result = a << b[4:0];
			end
			// imm into the upper half
			LUI: begin
				result = b << 16;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- logic/exec_top.sv
`include "exec_params.svh"

module exec_top (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic                  in_valid,
	input  uop_pkg::bundle_t      in_bundle,
	output logic                  in_credit,
	output logic                  out_valid,
	output wb_pkg::wb_beat_t      out_beat,
	input  logic                  out_credit,
	output logic [`EXEC_XLEN-1:0] link_reg
);
	import uop_pkg::*;
	import wb_pkg::*;

	bundle_t                       q_bundle;
	logic                          q_valid;
	logic                          q_pop;
	logic [3:0][`EXEC_RADDR_W-1:0] raddr;
	logic [3:0][`EXEC_XLEN-1:0]    rdata;
	uop_t                          alu_uop0;
	uop_t                          alu_uop1;
	logic [`EXEC_XLEN-1:0]         alu_a0;
	logic [`EXEC_XLEN-1:0]         alu_b0;
	logic [`EXEC_XLEN-1:0]         alu_a1;
	logic [`EXEC_XLEN-1:0]         alu_b1;
	logic [`EXEC_XLEN-1:0]         alu_res0;
	logic [`EXEC_XLEN-1:0]         alu_res1;
	wb_beat_t                      wb_q;

	assign out_beat = wb_q;

	bundle_queue u_queue (
		.clk        (clk),
		.aresetn    (aresetn),
		.push       (in_valid),
		.push_data  (in_bundle),
		.pop        (q_pop),
		.head       (q_bundle),
		.head_valid (q_valid),
		.credit     (in_credit)
	);

	issue_ctrl u_issue (
		.clk        (clk),
		.aresetn    (aresetn),
		.q_bundle   (q_bundle),
		.q_valid    (q_valid),
		.q_pop      (q_pop),
		.raddr      (raddr),
		.rdata      (rdata),
		.alu_uop0   (alu_uop0),
		.alu_uop1   (alu_uop1),
		.alu_a0     (alu_a0),
		.alu_b0     (alu_b0),
		.alu_a1     (alu_a1),
		.alu_b1     (alu_b1),
		.alu_res0   (alu_res0),
		.alu_res1   (alu_res1),
		.out_credit (out_credit),
		.wb_q       (wb_q),
		.out_valid  (out_valid)
	);

	// lane0 writes through port 1, lane1 through port 2
	regfile u_regfile (
		.clk      (clk),
		.aresetn  (aresetn),
		.we1      (wb_q.lane0.valid),
		.waddr1   (wb_q.lane0.rd),
		.wdata1   (wb_q.lane0.value),
		.we2      (wb_q.lane1.valid),
		.waddr2   (wb_q.lane1.rd),
		.wdata2   (wb_q.lane1.value),
		.raddr1   (raddr[0]),
		.raddr2   (raddr[1]),
		.raddr3   (raddr[2]),
		.raddr4   (raddr[3]),
		.rdata1   (rdata[0]),
		.rdata2   (rdata[1]),
		.rdata3   (rdata[2]),
		.rdata4   (rdata[3]),
		.link_reg (link_reg)
	);

	int_alu u_alu0 (
		.op     (alu_uop0.op),
		.a      (alu_a0),
		.b      (alu_b0),
		.result (alu_res0)
	);

	int_alu u_alu1 (
		.op     (alu_uop1.op),
		.a      (alu_a1),
		.b      (alu_b1),
		.result (alu_res1)
	);

endmodule

//--- tests/exec_assertions.sv
`include "exec_params.svh"

module exec_assertions (
	input logic clk,
	input logic aresetn,
	input logic in_valid,
	input logic in_credit,
	input logic out_valid,
	input logic out_credit,
	input logic q_pop
);
	timeunit 1ns;
	timeprecision 1ps;

	// credits held by the upstream and downstream sides
	int in_cnt;
	int out_cnt;
	// bundles accepted and not yet popped
	int q_cnt;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_cnt  <= `EXEC_IN_DEPTH;
			out_cnt <= `EXEC_OUT_CREDITS;
			q_cnt   <= 0;
		end else begin
			in_cnt  <= in_cnt - int'(in_valid) + int'(in_credit);
			out_cnt <= out_cnt - int'(out_valid) + int'(out_credit);
			q_cnt   <= q_cnt + int'(in_valid) - int'(q_pop);
		end
	end

	a_in_credit: assert property (@(posedge clk) disable iff (!aresetn)
		in_valid |-> in_cnt > 0)
		else $error("in_valid without an input credit");

	a_out_credit: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid |-> out_cnt > 0)
		else $error("out_valid without an output credit");

	a_pop_valid: assert property (@(posedge clk) disable iff (!aresetn)
		q_pop |-> q_cnt > 0)
		else $error("queue popped while empty");

	// credits returned must match the free entries
	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn)
		in_valid |-> q_cnt < `EXEC_IN_DEPTH)
		else $error("bundle pushed into a full queue");

endmodule

bind exec_top exec_assertions u_assert (
	.clk        (clk),
	.aresetn    (aresetn),
	.in_valid   (in_valid),
	.in_credit  (in_credit),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.q_pop      (q_pop)
);

//--- tests/exec_tb.sv
`include "exec_params.svh"

module exec_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import uop_pkg::*;
	import wb_pkg::*;

	typedef struct packed {
		bundle_t               bundle;
		logic                  split;
		logic [`EXEC_XLEN-1:0] v0;
		logic [`EXEC_XLEN-1:0] v1;
	} entry_t;

	logic                  clk;
	logic                  aresetn;
	logic                  in_valid;
	bundle_t               in_bundle;
	logic                  in_credit;
	logic                  out_valid;
	wb_beat_t              out_beat;
	logic                  out_credit = 1'b0;
	logic [`EXEC_XLEN-1:0] link_reg;

	entry_t                tbl[$];
	wb_beat_t              exp_q[$];
	wb_beat_t              exp_beat;
	int                    rel_q[$];
	int                    seed = 46652;
	int                    cyc;
	int                    sent;
	int                    returned;
	int                    seen;
	int                    n_beats;
	int                    limit;
	int                    delay;
	logic                  link_pending = 1'b0;
	logic [`EXEC_XLEN-1:0] link_exp;

	exec_top i_dut (
		.clk        (clk),
		.aresetn    (aresetn),
		.in_valid   (in_valid),
		.in_bundle  (in_bundle),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.out_credit (out_credit),
		.link_reg   (link_reg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_beat(input wb_beat_t got, input wb_beat_t exp);
		logic bad;
		bad = (got.lane0.valid !== exp.lane0.valid) || (got.lane1.valid !== exp.lane1.valid);
		if (exp.lane0.valid && (got.lane0.rd !== exp.lane0.rd ||
				got.lane0.value !== exp.lane0.value)) begin
			bad = 1'b1;
		end
		if (exp.lane1.valid && (got.lane1.rd !== exp.lane1.rd ||
				got.lane1.value !== exp.lane1.value)) begin
			bad = 1'b1;
		end
		if (bad) begin
			stop_with_failure($sformatf("MISMATCH out_beat got %h expected %h", got, exp));
		end
	endtask

	task automatic check_link(input logic [`EXEC_XLEN-1:0] got,
			input logic [`EXEC_XLEN-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH link_reg got %h expected %h", got, exp));
		end
	endtask

	function automatic uop_t make_uop(input alu_op_e op, input int rd, input int rs,
			input int rt, input int imm, input int use_imm);
		uop_t u;
		u.valid = 1'b1;
		u.op = op;
		u.rd = `EXEC_RADDR_W'(rd);
		u.rs = `EXEC_RADDR_W'(rs);
		u.rt = `EXEC_RADDR_W'(rt);
		u.imm = 16'(imm);
		u.use_imm = (use_imm != 0);
		return u;
	endfunction

	task automatic add_entry(input uop_t s0, input uop_t s1, input int split,
			input logic [`EXEC_XLEN-1:0] v0, input logic [`EXEC_XLEN-1:0] v1);
		entry_t e;
		e.bundle.slot0 = s0;
		e.bundle.slot1 = s1;
		e.split = (split != 0);
		e.v0 = v0;
		e.v1 = v1;
		tbl.push_back(e);
	endtask

	// bundle, split flag, slot0 result, slot1 result
	task automatic load_table();
		add_entry(make_uop(LUI, 2, 0, 0, 16'h1234, 1), make_uop(LUI, 3, 0, 0, 16'h8000, 1),
			0, 32'h1234_0000, 32'h8000_0000);
		add_entry(make_uop(OR, 2, 2, 0, 16'h5678, 1), make_uop(OR, 3, 3, 0, 16'h0001, 1),
			0, 32'h1234_5678, 32'h8000_0001);
		add_entry(make_uop(ADD, 4, 2, 3, 0, 0), make_uop(SUB, 5, 2, 3, 0, 0),
			0, 32'h9234_5679, 32'h9234_5677);
		add_entry(make_uop(AND, 6, 4, 5, 0, 0), make_uop(XOR, 7, 2, 3, 0, 0),
			0, 32'h9234_5671, 32'h9234_5679);
		add_entry(make_uop(SLT, 8, 3, 2, 0, 0), make_uop(SLL, 9, 2, 0, 4, 1),
			0, 32'h0000_0001, 32'h2345_6780);
		// slot1 depends on slot0
		add_entry(make_uop(ADD, 10, 8, 0, 16'h0010, 1), make_uop(SLL, 11, 10, 8, 0, 0),
			1, 32'h0000_0011, 32'h0000_0022);
		add_entry(make_uop(OR, 12, 0, 0, 16'h00aa, 1), make_uop(OR, 12, 0, 0, 16'h00bb, 1),
			0, 32'h0000_00aa, 32'h0000_00bb);
		add_entry(make_uop(OR, 0, 2, 0, 0, 1), make_uop(ADD, 13, 12, 0, 0, 0),
			0, 32'h1234_5678, 32'h0000_00bb);
		add_entry(make_uop(LUI, 1, 0, 0, 16'hbeef, 1), make_uop(ADD, 14, 0, 12, 0, 0),
			0, 32'hbeef_0000, 32'h0000_00bb);
		add_entry(make_uop(OR, 1, 1, 0, 16'h0001, 1), make_uop(LUI, 15, 0, 0, 16'h7fff, 1),
			0, 32'hbeef_0001, 32'h7fff_0000);
		add_entry(make_uop(SUB, 16, 15, 1, 0, 0), '0,
			0, 32'hc10f_ffff, 32'h0000_0000);
		add_entry(make_uop(SLT, 17, 2, 3, 0, 0), make_uop(XOR, 18, 16, 0, 16'hffff, 1),
			0, 32'h0000_0000, 32'hc10f_0000);
	endtask

	// a split bundle gives two lane0-only beats
	task automatic build_expected();
		wb_beat_t b;
		foreach (tbl[i]) begin
			b = '0;
			b.lane0 = '{tbl[i].bundle.slot0.valid, tbl[i].bundle.slot0.rd, tbl[i].v0};
			if (tbl[i].split) begin
				exp_q.push_back(b);
				b.lane0 = '{tbl[i].bundle.slot1.valid, tbl[i].bundle.slot1.rd, tbl[i].v1};
			end else begin
				b.lane1 = '{tbl[i].bundle.slot1.valid, tbl[i].bundle.slot1.rd, tbl[i].v1};
			end
			exp_q.push_back(b);
		end
	endtask

	// downstream model and watchdog
	always @(posedge clk) begin
		if (!aresetn) begin
			cyc <= 0;
			out_credit <= 1'b0;
		end else begin
			cyc <= cyc + 1;
			if (rel_q.size() != 0 && rel_q[0] <= cyc) begin
				out_credit <= 1'b1;
				void'(rel_q.pop_front());
			end else begin
				out_credit <= 1'b0;
			end
			if (cyc >= limit) begin
				stop_with_failure($sformatf("results did not arrive within %0d cycles", limit));
			end
		end
	end

	always @(negedge clk) begin
		if (aresetn) begin
			if (link_pending) begin
				check_link(link_reg, link_exp);
				link_pending = 1'b0;
			end
			if (in_credit) begin
				returned++;
			end
			if (out_valid && exp_q.size() == 0) begin
				stop_with_failure("out_valid rose with no beat left to expect");
			end else if (out_valid) begin
				exp_beat = exp_q.pop_front();
				check_beat(out_beat, exp_beat);
				seen++;
				if (exp_beat.lane1.valid && exp_beat.lane1.rd == 1) begin
					link_exp = exp_beat.lane1.value;
					link_pending = 1'b1;
				end else if (exp_beat.lane0.valid && exp_beat.lane0.rd == 1) begin
					link_exp = exp_beat.lane0.value;
					link_pending = 1'b1;
				end
				// credit goes back 0 to 3 cycles later, one pulse per beat
				delay = int'($unsigned($random(seed)) % 4);
				if (rel_q.size() != 0 && cyc + delay <= rel_q[$]) begin
					rel_q.push_back(rel_q[$] + 1);
				end else begin
					rel_q.push_back(cyc + delay);
				end
			end
		end
	end

	initial begin
		aresetn = 1'b0;
		in_valid = 1'b0;
		in_bundle = '0;
		load_table();
		build_expected();
		n_beats = exp_q.size();
		limit = tbl.size() * 10 + 100;
		repeat (4) @(posedge clk);
		aresetn <= 1'b1;
		@(posedge clk);
		foreach (tbl[i]) begin
			while (sent - returned >= `EXEC_IN_DEPTH) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_valid <= 1'b1;
			in_bundle <= tbl[i].bundle;
			sent++;
			@(posedge clk);
		end
		in_valid <= 1'b0;
		while (seen < n_beats) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		if (returned == sent) begin
			$display("test passed");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d input credits came back for %0d bundles sent",
				returned, sent));
		end
	end

endmodule

//--- sources.f
+incdir+logic
logic/uop_pkg.sv
logic/wb_pkg.sv
logic/bundle_queue.sv
logic/issue_ctrl.sv
logic/regfile.sv
logic/int_alu.sv
logic/exec_top.sv
tests/exec_assertions.sv
tests/exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := exec_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
